// File: src/pe_bus_pkg.sv
package pe_bus_pkg;

    ////////////////////////////////////////
    // Bus request
    ////////////////////////////////////////

    // One request on the core bus, valid only in the cycle en is high
    typedef struct packed {
        logic        en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    ////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////

    // Top address byte of each 16 MiB region
    typedef enum logic [7:0] {
        REGION_DMEM   = 8'h01,
        REGION_MTIMER = 8'h02,
        REGION_IRQ    = 8'h04
    } region_e;

    // Per-peripheral selects, at most one high
    typedef struct packed {
        logic dmem;
        logic mtimer;
        logic irq_ctrl;
    } periph_sel_t;

    // Offset width inside one region
    localparam int MEM_ADDR_W = 24;

    ////////////////////////////////////////
    // Register word offsets
    ////////////////////////////////////////

    // Machine timer
    localparam logic [1:0] MTIME_LO    = 2'd0;
    localparam logic [1:0] MTIME_HI    = 2'd1;
    localparam logic [1:0] MTIMECMP_LO = 2'd2;
    localparam logic [1:0] MTIMECMP_HI = 2'd3;

    // Interrupt controller
    localparam logic [1:0] IRQ_ENABLE  = 2'd0;
    localparam logic [1:0] IRQ_PENDING = 2'd1;
    localparam logic [1:0] IRQ_CLAIM   = 2'd2;

    localparam int N_IRQ_DEFAULT = 4;

endpackage

// File: src/pe_addr_decode.sv
`timescale 1ns/1ps

module pe_addr_decode (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  pe_bus_pkg::bus_req_t    bus_req_i,
    output pe_bus_pkg::periph_sel_t sel_o,
    input  logic [31:0]            mtimer_rdata_i,
    input  logic [31:0]            irq_rdata_i,
    input  logic [31:0]            dmem_rdata_i,
    output logic [31:0]            rdata_o
);

    import pe_bus_pkg::*;

    ////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////

    logic [7:0] region;

    assign region = bus_req_i.addr[31:24];

    // Each select needs an active request and a matching top byte
    assign sel_o.dmem     = bus_req_i.en && (region == REGION_DMEM);
    assign sel_o.mtimer   = bus_req_i.en && (region == REGION_MTIMER);
    assign sel_o.irq_ctrl = bus_req_i.en && (region == REGION_IRQ);

    ////////////////////////////////////////
    // Read return
    ////////////////////////////////////////

    // Peripheral read registers are valid one cycle after the request
    logic ret_mtimer_q;
    logic ret_irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ret_mtimer_q <= 1'b0;
            ret_irq_q    <= 1'b0;
        end else begin
            ret_mtimer_q <= sel_o.mtimer;
            ret_irq_q    <= sel_o.irq_ctrl;
        end
    end

    // Data memory also covers unmapped regions
    always_comb begin
        if (ret_mtimer_q) begin
            rdata_o = mtimer_rdata_i;
        end else if (ret_irq_q) begin
            rdata_o = irq_rdata_i;
        end else begin
            rdata_o = dmem_rdata_i;
        end
    end

endmodule

// File: src/pe_mtimer.sv
`timescale 1ns/1ps

module pe_mtimer (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  pe_bus_pkg::bus_req_t bus_req_i,
    input  logic                sel_i,
    output logic [31:0]         rdata_o,
    output logic                mti_o
);

    import pe_bus_pkg::*;

    logic [1:0]  word_off;
    logic        wr_en;
    logic [63:0] mtime_q;
    logic [63:0] mtime_d;
    logic [63:0] mtimecmp_q;
    logic [31:0] rd_data;
    logic [31:0] rdata_q;

    assign word_off = bus_req_i.addr[3:2];
    assign wr_en    = sel_i && (|bus_req_i.we);

    ////////////////////////////////////////
    // Free-running counter
    ////////////////////////////////////////

    // A write to either half replaces the count for that cycle
    always_comb begin
        mtime_d = mtime_q + 64'd1;
        if (wr_en) begin
            if (word_off == MTIME_LO) begin
                mtime_d = {mtime_q[63:32], bus_req_i.wdata};
            end else if (word_off == MTIME_HI) begin
                mtime_d = {bus_req_i.wdata, mtime_q[31:0]};
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_d;
        end
    end

    ////////////////////////////////////////
    // Compare register
    ////////////////////////////////////////

    // All ones out of reset keeps the interrupt quiet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (wr_en && (word_off == MTIMECMP_LO)) begin
            mtimecmp_q[31:0] <= bus_req_i.wdata;
        end else if (wr_en && (word_off == MTIMECMP_HI)) begin
            mtimecmp_q[63:32] <= bus_req_i.wdata;
        end
    end

    assign mti_o = (mtime_q >= mtimecmp_q);

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb begin
        case (word_off)
            MTIME_LO:    rd_data = mtime_q[31:0];
            MTIME_HI:    rd_data = mtime_q[63:32];
            MTIMECMP_LO: rd_data = mtimecmp_q[31:0];
            default:     rd_data = mtimecmp_q[63:32];
        endcase
    end

    // Captured at the request edge, shows up one cycle later
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_q <= rd_data;
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: src/pe_irq_ctrl.sv
`timescale 1ns/1ps

module pe_irq_ctrl #(
    parameter int unsigned N_IRQ = pe_bus_pkg::N_IRQ_DEFAULT
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  pe_bus_pkg::bus_req_t bus_req_i,
    input  logic                sel_i,
    input  logic [N_IRQ-1:0]    irq_src_i,
    output logic [31:0]         rdata_o,
    output logic                mei_o
);

    import pe_bus_pkg::*;

    logic [1:0]       word_off;
    logic             wr_en;
    logic             claim_rd;
    logic             complete_wr;
    logic [N_IRQ-1:0] enable_q;
    logic [N_IRQ-1:0] pending_q;
    logic [N_IRQ-1:0] in_service_q;
    logic [N_IRQ-1:0] active;
    logic [N_IRQ-1:0] claim_mask;
    logic [N_IRQ-1:0] complete_mask;
    logic [4:0]       claim_id;
    logic [31:0]      rd_data;
    logic [31:0]      rdata_q;

    assign word_off    = bus_req_i.addr[3:2];
    assign wr_en       = sel_i && (|bus_req_i.we);
    assign claim_rd    = sel_i && !(|bus_req_i.we) && (word_off == IRQ_CLAIM);
    assign complete_wr = wr_en && (word_off == IRQ_CLAIM);
    assign active      = pending_q & enable_q;

    ////////////////////////////////////////
    // Claim priority and complete decode
    ////////////////////////////////////////

    // Scan downwards so the lowest active source wins
    always_comb begin
        claim_id      = '0;
        claim_mask    = '0;
        complete_mask = '0;
        for (int i = N_IRQ - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id   = 5'(i + 1);
                claim_mask = '0;
                claim_mask[i] = claim_rd;
            end
            if (complete_wr && (bus_req_i.wdata == 32'(i + 1))) begin
                complete_mask[i] = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // State registers
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            if (wr_en && (word_off == IRQ_ENABLE)) begin
                enable_q <= bus_req_i.wdata[N_IRQ-1:0];
            end
            // A claimed source must not latch again until completed
            pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
        end
    end

    assign mei_o = |active;

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb begin
        rd_data = '0;
        case (word_off)
            IRQ_ENABLE:  rd_data[N_IRQ-1:0] = enable_q;
            IRQ_PENDING: rd_data[N_IRQ-1:0] = pending_q;
            IRQ_CLAIM:   rd_data[4:0]       = claim_id;
            default:     rd_data            = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_q <= rd_data;
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: src/pe_periph_top.sv
`timescale 1ns/1ps

module pe_periph_top #(
    parameter int unsigned N_IRQ = pe_bus_pkg::N_IRQ_DEFAULT
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    // Core bus
    input  pe_bus_pkg::bus_req_t               bus_req_i,
    output logic [31:0]                       rdata_o,

    // Data memory port
    output logic                              dmem_en_o,
    output logic [3:0]                        dmem_we_o,
    output logic [pe_bus_pkg::MEM_ADDR_W-1:0] dmem_addr_o,
    output logic [31:0]                       dmem_wdata_o,
    input  logic [31:0]                       dmem_rdata_i,

    // Interrupts
    input  logic [N_IRQ-1:0]                  irq_src_i,
    output logic                              mti_o,
    output logic                              mei_o
);

    import pe_bus_pkg::*;

    periph_sel_t sel;
    logic [31:0] mtimer_rdata;
    logic [31:0] irq_rdata;

    ////////////////////////////////////////
    // Decoder and return mux
    ////////////////////////////////////////

    pe_addr_decode i_addr_decode (
        .clk_i          (clk_i       ),
        .rst_ni         (rst_ni      ),
        .bus_req_i      (bus_req_i   ),
        .sel_o          (sel         ),
        .mtimer_rdata_i (mtimer_rdata),
        .irq_rdata_i    (irq_rdata   ),
        .dmem_rdata_i   (dmem_rdata_i),
        .rdata_o        (rdata_o     )
    );

    ////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////

    pe_mtimer i_mtimer (
        .clk_i     (clk_i       ),
        .rst_ni    (rst_ni      ),
        .bus_req_i (bus_req_i   ),
        .sel_i     (sel.mtimer  ),
        .rdata_o   (mtimer_rdata),
        .mti_o     (mti_o       )
    );

    pe_irq_ctrl #(
        .N_IRQ (N_IRQ)
    ) i_irq_ctrl (
        .clk_i     (clk_i       ),
        .rst_ni    (rst_ni      ),
        .bus_req_i (bus_req_i   ),
        .sel_i     (sel.irq_ctrl),
        .irq_src_i (irq_src_i   ),
        .rdata_o   (irq_rdata   ),
        .mei_o     (mei_o       )
    );

    ////////////////////////////////////////
    // Data memory port
    ////////////////////////////////////////

    // Strobes only reach memory for data-region requests
    assign dmem_en_o    = sel.dmem;
    assign dmem_we_o    = sel.dmem ? bus_req_i.we : 4'h0;
    assign dmem_addr_o  = bus_req_i.addr[MEM_ADDR_W-1:0];
    assign dmem_wdata_o = bus_req_i.wdata;

endmodule

// File: sim/pe_periph_properties.sv
`timescale 1ns/1ps

module pe_periph_properties (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  pe_bus_pkg::bus_req_t    bus_req_i,
    input  pe_bus_pkg::periph_sel_t sel_i,
    input  logic                    dmem_en_i,
    input  logic                    mti_i,
    input  logic                    mei_i
);

    import pe_bus_pkg::*;

    logic [2:0] sel_bits;

    assign sel_bits = {sel_i.dmem, sel_i.mtimer, sel_i.irq_ctrl};

    ////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////

    sel_onehot_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(sel_bits)
    ) else $error("More than one peripheral select is high");

    // Memory enable only for a live data-region request
    dmem_region_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        dmem_en_i |-> (bus_req_i.en && (bus_req_i.addr[31:24] == REGION_DMEM))
    ) else $error("Data memory enabled outside its region");

    ////////////////////////////////////////
    // Interrupts out of reset
    ////////////////////////////////////////

    irq_quiet_a: assert property (
        @(posedge clk_i) $rose(rst_ni) |-> (!mti_i && !mei_i)
    ) else $error("Interrupt output high in the first cycle after reset");

endmodule

bind pe_periph_top pe_periph_properties i_properties (
    .clk_i     (clk_i    ),
    .rst_ni    (rst_ni   ),
    .bus_req_i (bus_req_i),
    .sel_i     (sel      ),
    .dmem_en_i (dmem_en_o),
    .mti_i     (mti_o    ),
    .mei_i     (mei_o    )
);

// File: sim/tb_pe_periph.sv
`timescale 1ns/1ps

module tb_pe_periph;

    import pe_bus_pkg::*;

    localparam int N_IRQ          = 4;
    localparam int N_STEPS        = 30;
    localparam int TIMEOUT_CYCLES = 2 * N_STEPS + 100;

    // How the returned read data of a step is checked
    localparam logic [1:0] RD_NONE     = 2'd0;
    localparam logic [1:0] RD_VALUE    = 2'd1;
    localparam logic [1:0] RD_INIT_MEM = 2'd2;

    // Register addresses
    localparam logic [31:0] A_MTIME_LO    = 32'h0200_0000;
    localparam logic [31:0] A_MTIME_HI    = 32'h0200_0004;
    localparam logic [31:0] A_MTIMECMP_LO = 32'h0200_0008;
    localparam logic [31:0] A_MTIMECMP_HI = 32'h0200_000c;
    localparam logic [31:0] A_IRQ_ENABLE  = 32'h0400_0000;
    localparam logic [31:0] A_IRQ_PENDING = 32'h0400_0004;
    localparam logic [31:0] A_IRQ_CLAIM   = 32'h0400_0008;

    // One table row, expected values seen in the cycle after the request
    typedef struct packed {
        bus_req_t         req;
        logic [N_IRQ-1:0] irq_src;
        logic [1:0]       rd_mode;
        logic [31:0]      exp_rdata;
        logic             exp_mti;
        logic             exp_mei;
    } step_t;

    logic                  clk_i;
    logic                  rst_ni;
    bus_req_t              bus_req;
    logic [31:0]           rdata;
    logic                  dmem_en;
    logic [3:0]            dmem_we;
    logic [MEM_ADDR_W-1:0] dmem_addr;
    logic [31:0]           dmem_wdata;
    logic [31:0]           dmem_rdata = '0;
    logic [N_IRQ-1:0]      irq_src;
    logic                  mti;
    logic                  mei;

    step_t       steps [N_STEPS];
    int          n_fill = 0;
    int          cycle_cnt = 0;
    logic [31:0] seed = 32'h472b;
    logic [31:0] dmem_words [64];
    logic [31:0] dmem_init [64];
    logic [5:0]  dmem_idx;

    pe_periph_top #(
        .N_IRQ (N_IRQ)
    ) i_dut (
        .clk_i        (clk_i     ),
        .rst_ni       (rst_ni    ),
        .bus_req_i    (bus_req   ),
        .rdata_o      (rdata     ),
        .dmem_en_o    (dmem_en   ),
        .dmem_we_o    (dmem_we   ),
        .dmem_addr_o  (dmem_addr ),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata),
        .irq_src_i    (irq_src   ),
        .mti_o        (mti       ),
        .mei_o        (mei       )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Data memory model
    ////////////////////////////////////////

    assign dmem_idx = dmem_addr[7:2];

    initial begin
        for (int i = 0; i < 64; i++) begin
            dmem_words[i] = $random(seed);
            dmem_init[i]  = dmem_words[i];
        end
    end

    // Synchronous read of the addressed word, one cycle latency
    always @(posedge clk_i) begin
        dmem_rdata <= dmem_words[dmem_idx];
        if (dmem_en && (|dmem_we)) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_we[b]) begin
                    dmem_words[dmem_idx][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Reporting and checks
    ////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: run did not end within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    task automatic check_rdata(input logic [31:0] act, input logic [31:0] exp, input int step);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch at %0t: step %0d rdata 0x%08h, expected 0x%08h",
                                     $time, step, act, exp));
        end
    endtask

    task automatic check_irq(input logic act_mti, input logic act_mei,
                             input logic exp_mti, input logic exp_mei, input int step);
        if ((act_mti !== exp_mti) || (act_mei !== exp_mei)) begin
            report_failure($sformatf("Mismatch at %0t: step %0d mti/mei %b/%b, expected %b/%b",
                                     $time, step, act_mti, act_mei, exp_mti, exp_mei));
        end
    endtask

    task automatic check_dmem(input bus_req_t exp, input int step);
        if ((dmem_en !== exp.en) || (dmem_we !== exp.we) ||
            (dmem_addr !== exp.addr[MEM_ADDR_W-1:0]) || (dmem_wdata !== exp.wdata)) begin
            report_failure($sformatf("Mismatch at %0t: step %0d dmem port en %b we %h addr %h",
                                     $time, step, dmem_en, dmem_we, dmem_addr));
        end
    endtask

    // Memory port only opens for data-region requests
    function automatic bus_req_t expected_port(input bus_req_t req);
        bus_req_t port;
        port      = req;
        port.addr = {8'h00, req.addr[MEM_ADDR_W-1:0]};
        port.en   = req.en && (req.addr[31:24] == REGION_DMEM);
        if (!port.en) begin
            port.we = 4'h0;
        end
        return port;
    endfunction

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    function automatic bus_req_t write_req(input logic [31:0] addr, input logic [31:0] data);
        bus_req_t req;
        req.en    = 1'b1;
        req.we    = 4'hf;
        req.addr  = addr;
        req.wdata = data;
        return req;
    endfunction

    function automatic bus_req_t read_req(input logic [31:0] addr);
        bus_req_t req;
        req       = '0;
        req.en    = 1'b1;
        req.addr  = addr;
        return req;
    endfunction

    task automatic add_step(input bus_req_t req, input logic [N_IRQ-1:0] src,
                            input logic [1:0] mode, input logic [31:0] exp,
                            input logic exp_mti, input logic exp_mei);
        steps[n_fill] = {req, src, mode, exp, exp_mti, exp_mei};
        n_fill++;
    endtask

    task automatic fill_table();
        // Data memory, then an unmapped region read
        add_step(write_req(32'h0100_0010, 32'hcafe_0001), 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step(read_req(32'h0100_0010), 4'h0, RD_VALUE, 32'hcafe_0001, 1'b0, 1'b0);
        add_step(read_req(32'h0100_0024), 4'h0, RD_INIT_MEM, 32'd9, 1'b0, 1'b0);
        add_step(read_req(32'h0800_0030), 4'h0, RD_INIT_MEM, 32'd12, 1'b0, 1'b0);
        // Timer words, two idle cycles before the mtime low read
        add_step(write_req(A_MTIME_HI, 32'h0000_0012), 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step(read_req(A_MTIME_HI), 4'h0, RD_VALUE, 32'h0000_0012, 1'b0, 1'b0);
        add_step(write_req(A_MTIME_LO, 32'h0000_1000), 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step('0, 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step('0, 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step(read_req(A_MTIME_LO), 4'h0, RD_VALUE, 32'h0000_1002, 1'b0, 1'b0);
        // Compare above mtime, then below it, then out of reach
        add_step(write_req(A_MTIMECMP_HI, 32'h0000_0012), 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step(write_req(A_MTIMECMP_LO, 32'h0000_2000), 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step(read_req(A_MTIMECMP_LO), 4'h0, RD_VALUE, 32'h0000_2000, 1'b0, 1'b0);
        add_step(write_req(A_MTIMECMP_LO, 32'h0000_1000), 4'h0, RD_NONE, '0, 1'b1, 1'b0);
        add_step('0, 4'h0, RD_NONE, '0, 1'b1, 1'b0);
        add_step(write_req(A_MTIMECMP_HI, 32'hffff_ffff), 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        // Sources pending with enable off, then enabled
        add_step('0, 4'h6, RD_NONE, '0, 1'b0, 1'b0);
        add_step(read_req(A_IRQ_PENDING), 4'h6, RD_VALUE, 32'h6, 1'b0, 1'b0);
        add_step(write_req(A_IRQ_ENABLE, 32'h0000_000f), 4'h6, RD_NONE, '0, 1'b0, 1'b1);
        add_step(read_req(A_IRQ_ENABLE), 4'h6, RD_VALUE, 32'hf, 1'b0, 1'b1);
        // Claims in id order, completes and re-pending of a held source
        add_step(read_req(A_IRQ_CLAIM), 4'h2, RD_VALUE, 32'd2, 1'b0, 1'b1);
        add_step(read_req(A_IRQ_CLAIM), 4'h2, RD_VALUE, 32'd3, 1'b0, 1'b0);
        add_step(read_req(A_IRQ_CLAIM), 4'h2, RD_VALUE, 32'd0, 1'b0, 1'b0);
        add_step(write_req(A_IRQ_CLAIM, 32'd2), 4'h2, RD_NONE, '0, 1'b0, 1'b0);
        add_step('0, 4'h2, RD_NONE, '0, 1'b0, 1'b1);
        add_step(read_req(A_IRQ_PENDING), 4'h2, RD_VALUE, 32'h2, 1'b0, 1'b1);
        add_step(write_req(A_IRQ_CLAIM, 32'd3), 4'h0, RD_NONE, '0, 1'b0, 1'b1);
        add_step(read_req(A_IRQ_CLAIM), 4'h0, RD_VALUE, 32'd2, 1'b0, 1'b0);
        add_step(write_req(A_IRQ_CLAIM, 32'd2), 4'h0, RD_NONE, '0, 1'b0, 1'b0);
        add_step(read_req(A_IRQ_PENDING), 4'h0, RD_VALUE, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic check_step(input int idx);
        if (steps[idx].rd_mode == RD_VALUE) begin
            check_rdata(rdata, steps[idx].exp_rdata, idx);
        end else if (steps[idx].rd_mode == RD_INIT_MEM) begin
            check_rdata(rdata, dmem_init[steps[idx].exp_rdata[5:0]], idx);
        end
        check_irq(mti, mei, steps[idx].exp_mti, steps[idx].exp_mei, idx);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        rst_ni  = 1'b0;
        bus_req = '0;
        irq_src = '0;
        fill_table();
        if (n_fill != N_STEPS) begin
            report_failure($sformatf("Stimulus table holds %0d rows instead of %0d",
                                     n_fill, N_STEPS));
        end
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // Results of row k are checked one cycle after it is driven
        for (int k = 0; k <= N_STEPS; k++) begin
            @(posedge clk_i);
            #1;
            if (k > 0) begin
                check_step(k - 1);
            end
            if (k < N_STEPS) begin
                bus_req = steps[k].req;
                irq_src = steps[k].irq_src;
                #1;
                check_dmem(expected_port(steps[k].req), k);
            end else begin
                bus_req = '0;
                irq_src = '0;
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog.f
src/pe_bus_pkg.sv
src/pe_addr_decode.sv
src/pe_mtimer.sv
src/pe_irq_ctrl.sv
src/pe_periph_top.sv
sim/pe_periph_properties.sv
sim/tb_pe_periph.sv

// File: Makefile
TOP := tb_pe_periph

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) --Mdir obj_dir -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
